// File: cpuControlPkg.sv
package cpuControlPkg;

  // Field and select widths
  localparam int OpcodeW   = 6;
  localparam int FunctW    = 6;
  localparam int AluOpW    = 3;
  localparam int PcSourceW = 3;
  localparam int IorDW     = 3;
  localparam int MemToRegW = 3;
  localparam int RegDstW   = 2;
  localparam int AluSrcBW  = 2;
  localparam int LsSizeW   = 2;
  localparam int CondW     = 2;
  localparam int ClassW    = 5;
  localparam int StepW     = 5;

  typedef logic [OpcodeW-1:0]   opcodeT;
  typedef logic [FunctW-1:0]    functT;
  typedef logic [AluOpW-1:0]    aluOpT;
  typedef logic [PcSourceW-1:0] pcSourceT;
  typedef logic [IorDW-1:0]     iorDT;
  typedef logic [MemToRegW-1:0] memToRegT;
  typedef logic [RegDstW-1:0]   regDstT;
  typedef logic [AluSrcBW-1:0]  aluSrcBT;
  typedef logic [LsSizeW-1:0]   lsSizeT;
  typedef logic [CondW-1:0]     condT;

  localparam aluOpT AluPass = 3'b000;
  localparam aluOpT AluAdd  = 3'b001;
  localparam aluOpT AluSub  = 3'b010;
  localparam aluOpT AluAnd  = 3'b011;
  localparam aluOpT AluCmp  = 3'b111;

  localparam pcSourceT PcAluResult  = 3'b000;
  localparam pcSourceT PcJumpTarget = 3'b001;
  localparam pcSourceT PcMemVector  = 3'b010;
  localparam pcSourceT PcAluOut     = 3'b011;

  // Exception vectors live at fixed memory addresses
  localparam iorDT AddrPc          = 3'b000;
  localparam iorDT AddrAluOut      = 3'b001;
  localparam iorDT AddrBadOpVector = 3'b010;
  localparam iorDT AddrOvfVector   = 3'b011;

  localparam memToRegT WbAluOut  = 3'b000;
  localparam memToRegT WbMemLoad = 3'b101;

  localparam regDstT DstRt = 2'b00;
  localparam regDstT DstRd = 2'b01;
  localparam regDstT DstRa = 2'b11;

  localparam aluSrcBT SrcBReg      = 2'b00;
  localparam aluSrcBT SrcBImm      = 2'b01;
  localparam aluSrcBT SrcBImmShift = 2'b10;
  localparam aluSrcBT SrcBFour     = 2'b11;

  localparam lsSizeT SizeByte = 2'b01;
  localparam lsSizeT SizeHalf = 2'b10;
  localparam lsSizeT SizeWord = 2'b11;

  localparam condT CondNe = 2'b00;
  localparam condT CondEq = 2'b01;
  localparam condT CondLe = 2'b10;
  localparam condT CondGt = 2'b11;

  localparam opcodeT OpTypeR = 6'h00;
  localparam opcodeT OpJ     = 6'h02;
  localparam opcodeT OpJal   = 6'h03;
  localparam opcodeT OpBeq   = 6'h04;
  localparam opcodeT OpBne   = 6'h05;
  localparam opcodeT OpBle   = 6'h06;
  localparam opcodeT OpBgt   = 6'h07;
  localparam opcodeT OpAddi  = 6'h08;
  localparam opcodeT OpAddiu = 6'h09;
  localparam opcodeT OpSlti  = 6'h0A;
  localparam opcodeT OpLb    = 6'h20;
  localparam opcodeT OpLh    = 6'h21;
  localparam opcodeT OpLw    = 6'h23;
  localparam opcodeT OpSb    = 6'h28;
  localparam opcodeT OpSh    = 6'h29;
  localparam opcodeT OpSw    = 6'h2B;

  localparam functT FunJr  = 6'h08;
  localparam functT FunAdd = 6'h20;
  localparam functT FunSub = 6'h22;
  localparam functT FunAnd = 6'h24;
  localparam functT FunSlt = 6'h2A;

  typedef enum logic [ClassW-1:0] {
    ClsAdd, ClsAnd, ClsSub, ClsAddi, ClsAddiu, ClsSlt, ClsSlti,
    ClsLb, ClsLh, ClsLw, ClsSb, ClsSh, ClsSw,
    ClsBeq, ClsBne, ClsBle, ClsBgt,
    ClsJ, ClsJal, ClsJr,
    ClsInvalid
  } instClassE;

  typedef enum logic [StepW-1:0] {
    StReset    = 5'd0,
    StFetch    = 5'd1,
    StWait     = 5'd2,
    StDecode   = 5'd3,
    StAluExec  = 5'd4,
    StAluWrite = 5'd5,
    StOvf1     = 5'd6,
    StOvf2     = 5'd7,
    StBadOp1   = 5'd8,
    StBadOp2   = 5'd9,
    StMemAddr  = 5'd10,
    StLoadRead = 5'd11,
    StLoadWrite = 5'd12,
    StStore    = 5'd13,
    StBranch   = 5'd14,
    StJalLink  = 5'd15,
    StJalSave  = 5'd16,
    StJump     = 5'd17,
    StJrAddr   = 5'd18,
    StJrJump   = 5'd19
  } stepE;

endpackage

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  cpuControlPkg::opcodeT    opcode,
  input  cpuControlPkg::functT     funct,
  output cpuControlPkg::instClassE instClass
);

  cpuControlPkg::instClassE rClass;

  // R-type class comes from the funct field
  always_comb begin
    case (funct)
      cpuControlPkg::FunAdd: rClass = cpuControlPkg::ClsAdd;
      cpuControlPkg::FunAnd: rClass = cpuControlPkg::ClsAnd;
      cpuControlPkg::FunSub: rClass = cpuControlPkg::ClsSub;
      cpuControlPkg::FunSlt: rClass = cpuControlPkg::ClsSlt;
      cpuControlPkg::FunJr:  rClass = cpuControlPkg::ClsJr;
      default:               rClass = cpuControlPkg::ClsInvalid;
    endcase
  end

  always_comb begin
    case (opcode)
      cpuControlPkg::OpTypeR: instClass = rClass;

      // Immediate arithmetic and compare
      cpuControlPkg::OpAddi:  instClass = cpuControlPkg::ClsAddi;
      cpuControlPkg::OpAddiu: instClass = cpuControlPkg::ClsAddiu;
      cpuControlPkg::OpSlti:  instClass = cpuControlPkg::ClsSlti;

      // Memory access
      cpuControlPkg::OpLb: instClass = cpuControlPkg::ClsLb;
      cpuControlPkg::OpLh: instClass = cpuControlPkg::ClsLh;
      cpuControlPkg::OpLw: instClass = cpuControlPkg::ClsLw;
      cpuControlPkg::OpSb: instClass = cpuControlPkg::ClsSb;
      cpuControlPkg::OpSh: instClass = cpuControlPkg::ClsSh;
      cpuControlPkg::OpSw: instClass = cpuControlPkg::ClsSw;

      // Branches
      cpuControlPkg::OpBeq: instClass = cpuControlPkg::ClsBeq;
      cpuControlPkg::OpBne: instClass = cpuControlPkg::ClsBne;
      cpuControlPkg::OpBle: instClass = cpuControlPkg::ClsBle;
      cpuControlPkg::OpBgt: instClass = cpuControlPkg::ClsBgt;

      cpuControlPkg::OpJ:   instClass = cpuControlPkg::ClsJ;
      cpuControlPkg::OpJal: instClass = cpuControlPkg::ClsJal;

      default: instClass = cpuControlPkg::ClsInvalid;
    endcase
  end

endmodule

// File: stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer (
  input  logic                     clk,
  input  logic                     reset_in,
  input  cpuControlPkg::instClassE instClass,
  input  logic                     overflow,
  output cpuControlPkg::stepE      step
);

  cpuControlPkg::stepE nextStep;
  logic ovfClass;
  logic loadClass;

  // slt and slti never trap
  always_comb begin
    case (instClass)
      cpuControlPkg::ClsAdd,
      cpuControlPkg::ClsAnd,
      cpuControlPkg::ClsSub,
      cpuControlPkg::ClsAddi,
      cpuControlPkg::ClsAddiu: ovfClass = 1'b1;
      default:                 ovfClass = 1'b0;
    endcase
  end

  assign loadClass = (instClass == cpuControlPkg::ClsLb) ||
                     (instClass == cpuControlPkg::ClsLh) ||
                     (instClass == cpuControlPkg::ClsLw);

  always_comb begin
    nextStep = cpuControlPkg::StFetch;
    case (step)
      cpuControlPkg::StReset: nextStep = cpuControlPkg::StFetch;
      cpuControlPkg::StFetch: nextStep = cpuControlPkg::StWait;
      cpuControlPkg::StWait:  nextStep = cpuControlPkg::StDecode;
      cpuControlPkg::StDecode: begin
        case (instClass)
          cpuControlPkg::ClsAdd, cpuControlPkg::ClsAnd, cpuControlPkg::ClsSub,
          cpuControlPkg::ClsAddi, cpuControlPkg::ClsAddiu,
          cpuControlPkg::ClsSlt, cpuControlPkg::ClsSlti:
            nextStep = cpuControlPkg::StAluExec;
          cpuControlPkg::ClsLb, cpuControlPkg::ClsLh, cpuControlPkg::ClsLw,
          cpuControlPkg::ClsSb, cpuControlPkg::ClsSh, cpuControlPkg::ClsSw:
            nextStep = cpuControlPkg::StMemAddr;
          cpuControlPkg::ClsBeq, cpuControlPkg::ClsBne,
          cpuControlPkg::ClsBle, cpuControlPkg::ClsBgt:
            nextStep = cpuControlPkg::StBranch;
          cpuControlPkg::ClsJ:   nextStep = cpuControlPkg::StJump;
          cpuControlPkg::ClsJal: nextStep = cpuControlPkg::StJalLink;
          cpuControlPkg::ClsJr:  nextStep = cpuControlPkg::StJrAddr;
          default:               nextStep = cpuControlPkg::StBadOp1;
        endcase
      end
      cpuControlPkg::StAluExec: nextStep = cpuControlPkg::StAluWrite;
      cpuControlPkg::StAluWrite: begin
        // Overflow is only looked at here
        if (overflow && ovfClass) begin
          nextStep = cpuControlPkg::StOvf1;
        end
      end
      cpuControlPkg::StOvf1:   nextStep = cpuControlPkg::StOvf2;
      cpuControlPkg::StBadOp1: nextStep = cpuControlPkg::StBadOp2;
      cpuControlPkg::StMemAddr: begin
        if (loadClass) begin
          nextStep = cpuControlPkg::StLoadRead;
        end else begin
          nextStep = cpuControlPkg::StStore;
        end
      end
      cpuControlPkg::StLoadRead: nextStep = cpuControlPkg::StLoadWrite;
      cpuControlPkg::StJalLink:  nextStep = cpuControlPkg::StJalSave;
      cpuControlPkg::StJalSave:  nextStep = cpuControlPkg::StJump;
      cpuControlPkg::StJrAddr:   nextStep = cpuControlPkg::StJrJump;
      default:                   nextStep = cpuControlPkg::StFetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      step <= cpuControlPkg::StReset;
    end else begin
      step <= nextStep;
    end
  end

  aResetHolds: assert property (@(posedge clk) reset_in |=> step == cpuControlPkg::StReset)
    else $error("step left reset state while reset_in was high");

  aStepKnown: assert property (@(posedge clk) disable iff (reset_in)
    !$isunknown(step) &&
    (step inside {[cpuControlPkg::StReset : cpuControlPkg::StJrJump]}))
    else $error("step reached an unknown value %0d", step);

endmodule

// File: controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder (
  input  cpuControlPkg::stepE      step,
  input  cpuControlPkg::instClassE instClass,
  output logic                     pcWriteCond,
  output logic                     pcWrite,
  output logic                     memRead,
  output logic                     memWrite,
  output logic                     irWrite,
  output logic                     regWrite,
  output logic                     memData,
  output logic                     aluSrcA,
  output logic                     lsControl,
  output logic                     ltOut,
  output cpuControlPkg::condT      condControl,
  output cpuControlPkg::aluOpT     aluOp,
  output cpuControlPkg::lsSizeT    lsSize,
  output cpuControlPkg::iorDT      iorD,
  output cpuControlPkg::regDstT    regDst,
  output cpuControlPkg::memToRegT  memToReg,
  output cpuControlPkg::aluSrcBT   aluSrcB,
  output cpuControlPkg::pcSourceT  pcSource
);

  cpuControlPkg::aluOpT   execOp;
  cpuControlPkg::aluSrcBT execSrcB;
  cpuControlPkg::lsSizeT  sizeSel;
  cpuControlPkg::condT    condSel;
  logic                   isCompare;

  // Class-dependent fields, picked up by the step decode below
  always_comb begin
    execOp    = cpuControlPkg::AluAdd;
    execSrcB  = cpuControlPkg::SrcBReg;
    isCompare = 1'b0;
    case (instClass)
      cpuControlPkg::ClsAnd:   execOp = cpuControlPkg::AluAnd;
      cpuControlPkg::ClsSub:   execOp = cpuControlPkg::AluSub;
      cpuControlPkg::ClsAddi:  execSrcB = cpuControlPkg::SrcBImm;
      cpuControlPkg::ClsAddiu: execSrcB = cpuControlPkg::SrcBImm;
      cpuControlPkg::ClsSlt: begin
        execOp    = cpuControlPkg::AluCmp;
        isCompare = 1'b1;
      end
      cpuControlPkg::ClsSlti: begin
        execOp    = cpuControlPkg::AluCmp;
        execSrcB  = cpuControlPkg::SrcBImm;
        isCompare = 1'b1;
      end
      default: execOp = cpuControlPkg::AluAdd;
    endcase
  end

  always_comb begin
    case (instClass)
      cpuControlPkg::ClsLb, cpuControlPkg::ClsSb: sizeSel = cpuControlPkg::SizeByte;
      cpuControlPkg::ClsLh, cpuControlPkg::ClsSh: sizeSel = cpuControlPkg::SizeHalf;
      default:                                    sizeSel = cpuControlPkg::SizeWord;
    endcase
  end

  always_comb begin
    case (instClass)
      cpuControlPkg::ClsBeq: condSel = cpuControlPkg::CondEq;
      cpuControlPkg::ClsBle: condSel = cpuControlPkg::CondLe;
      cpuControlPkg::ClsBgt: condSel = cpuControlPkg::CondGt;
      default:               condSel = cpuControlPkg::CondNe;
    endcase
  end

  always_comb begin
    pcWriteCond = 1'b0;
    pcWrite     = 1'b0;
    memRead     = 1'b0;
    memWrite    = 1'b0;
    irWrite     = 1'b0;
    regWrite    = 1'b0;
    memData     = 1'b0;
    aluSrcA     = 1'b0;
    lsControl   = 1'b0;
    ltOut       = 1'b0;
    condControl = cpuControlPkg::CondNe;
    aluOp       = cpuControlPkg::AluPass;
    lsSize      = '0;
    iorD        = cpuControlPkg::AddrPc;
    regDst      = cpuControlPkg::DstRt;
    memToReg    = cpuControlPkg::WbAluOut;
    aluSrcB     = cpuControlPkg::SrcBReg;
    pcSource    = cpuControlPkg::PcAluResult;
    case (step)
      cpuControlPkg::StFetch: begin
        memRead = 1'b1;
        irWrite = 1'b1;
        pcWrite = 1'b1;
        aluSrcB = cpuControlPkg::SrcBFour;
        aluOp   = cpuControlPkg::AluAdd;
      end
      // Branch target computed early
      cpuControlPkg::StDecode: begin
        aluSrcB = cpuControlPkg::SrcBImmShift;
        aluOp   = cpuControlPkg::AluAdd;
      end
      cpuControlPkg::StAluExec: begin
        aluSrcA = 1'b1;
        aluSrcB = execSrcB;
        aluOp   = execOp;
      end
      cpuControlPkg::StAluWrite: begin
        regWrite = 1'b1;
        regDst   = cpuControlPkg::DstRd;
        ltOut    = isCompare;
      end
      cpuControlPkg::StOvf2: begin
        memRead  = 1'b1;
        pcWrite  = 1'b1;
        pcSource = cpuControlPkg::PcMemVector;
        iorD     = cpuControlPkg::AddrOvfVector;
      end
      cpuControlPkg::StBadOp2: begin
        memRead  = 1'b1;
        pcWrite  = 1'b1;
        pcSource = cpuControlPkg::PcMemVector;
        iorD     = cpuControlPkg::AddrBadOpVector;
      end
      cpuControlPkg::StMemAddr: begin
        aluSrcA = 1'b1;
        aluSrcB = cpuControlPkg::SrcBImm;
        aluOp   = cpuControlPkg::AluAdd;
      end
      cpuControlPkg::StLoadRead: begin
        memRead = 1'b1;
        iorD    = cpuControlPkg::AddrAluOut;
      end
      cpuControlPkg::StLoadWrite: begin
        regWrite = 1'b1;
        memToReg = cpuControlPkg::WbMemLoad;
        lsSize   = sizeSel;
      end
      cpuControlPkg::StStore: begin
        memWrite  = 1'b1;
        memData   = 1'b1;
        lsControl = 1'b1;
        iorD      = cpuControlPkg::AddrAluOut;
        lsSize    = sizeSel;
      end
      cpuControlPkg::StBranch: begin
        pcWriteCond = 1'b1;
        aluSrcA     = 1'b1;
        aluOp       = cpuControlPkg::AluCmp;
        pcSource    = cpuControlPkg::PcAluOut;
        condControl = condSel;
      end
      // Return address is PC + 4
      cpuControlPkg::StJalLink: begin
        aluSrcB = cpuControlPkg::SrcBFour;
        aluOp   = cpuControlPkg::AluAdd;
      end
      cpuControlPkg::StJalSave: begin
        regWrite = 1'b1;
        regDst   = cpuControlPkg::DstRa;
      end
      cpuControlPkg::StJump: begin
        pcWrite  = 1'b1;
        pcSource = cpuControlPkg::PcJumpTarget;
      end
      cpuControlPkg::StJrAddr: begin
        aluSrcA = 1'b1;
        aluOp   = cpuControlPkg::AluPass;
      end
      cpuControlPkg::StJrJump: begin
        pcWrite  = 1'b1;
        pcSource = cpuControlPkg::PcAluOut;
      end
      default: pcWrite = 1'b0;
    endcase
  end

  // Single memory port
  always_comb begin
    assert (!(memRead && memWrite))
      else $error("memRead and memWrite both high in step %0d", step);
  end

endmodule

// File: cpuControl.sv
`timescale 1ns/1ps

module cpuControl (
  input  logic                    clk,
  input  logic                    reset_in,
  input  cpuControlPkg::opcodeT   opcode,
  input  cpuControlPkg::functT    funct,
  input  logic                    overflow,
  output logic                    pcWriteCond,
  output logic                    pcWrite,
  output logic                    memRead,
  output logic                    memWrite,
  output logic                    irWrite,
  output logic                    regWrite,
  output logic                    memData,
  output logic                    aluSrcA,
  output logic                    lsControl,
  output logic                    ltOut,
  output cpuControlPkg::condT     condControl,
  output cpuControlPkg::aluOpT    aluOp,
  output cpuControlPkg::lsSizeT   lsSize,
  output cpuControlPkg::iorDT     iorD,
  output cpuControlPkg::regDstT   regDst,
  output cpuControlPkg::memToRegT memToReg,
  output cpuControlPkg::aluSrcBT  aluSrcB,
  output cpuControlPkg::pcSourceT pcSource
);

  cpuControlPkg::instClassE instClass;
  cpuControlPkg::stepE      step;

  instrDecoder uDecoder (
    .opcode    (opcode),
    .funct     (funct),
    .instClass (instClass)
  );

  stepSequencer uSequencer (
    .clk       (clk),
    .reset_in  (reset_in),
    .instClass (instClass),
    .overflow  (overflow),
    .step      (step)
  );

  controlEncoder uEncoder (
    .step        (step),
    .instClass   (instClass),
    .pcWriteCond (pcWriteCond),
    .pcWrite     (pcWrite),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .irWrite     (irWrite),
    .regWrite    (regWrite),
    .memData     (memData),
    .aluSrcA     (aluSrcA),
    .lsControl   (lsControl),
    .ltOut       (ltOut),
    .condControl (condControl),
    .aluOp       (aluOp),
    .lsSize      (lsSize),
    .iorD        (iorD),
    .regDst      (regDst),
    .memToReg    (memToReg),
    .aluSrcB     (aluSrcB),
    .pcSource    (pcSource)
  );

endmodule

// File: cpuControlRef.svh
`ifndef CPU_CONTROL_REF_SVH
`define CPU_CONTROL_REF_SVH

// Expected control word for one step of one instruction
// Bit order matches dutWord in the testbench
function automatic logic [29:0] expectedControl(
  input  cpuControlPkg::opcodeT op,
  input  cpuControlPkg::functT  fn,
  input  logic                  ovf,
  input  int                    idx,
  output logic                  last
);
  logic pwc, pw, mr, mw, irw, rw, md, asa, lsc, lt;
  cpuControlPkg::condT     cond;
  cpuControlPkg::aluOpT    alu;
  cpuControlPkg::lsSizeT   size;
  cpuControlPkg::iorDT     addr;
  cpuControlPkg::regDstT   dst;
  cpuControlPkg::memToRegT wb;
  cpuControlPkg::aluSrcBT  srcB;
  cpuControlPkg::pcSourceT pcSrc;
  cpuControlPkg::aluOpT    execAlu;
  cpuControlPkg::lsSizeT   sz;
  cpuControlPkg::condT     cnd;
  logic                    immB;
  logic                    cmp;
  logic                    trap;
  string                   kind;
  int                      j;
  kind    = "bad";
  execAlu = cpuControlPkg::AluAdd;
  sz      = cpuControlPkg::SizeWord;
  cnd     = cpuControlPkg::CondNe;
  immB    = 1'b0;
  cmp     = 1'b0;
  trap    = 1'b0;
  case (op)
    cpuControlPkg::OpTypeR: begin
      case (fn)
        cpuControlPkg::FunAdd: begin
          kind = "alu";
          trap = 1'b1;
        end
        cpuControlPkg::FunAnd: begin
          kind    = "alu";
          trap    = 1'b1;
          execAlu = cpuControlPkg::AluAnd;
        end
        cpuControlPkg::FunSub: begin
          kind    = "alu";
          trap    = 1'b1;
          execAlu = cpuControlPkg::AluSub;
        end
        cpuControlPkg::FunSlt: begin
          kind    = "alu";
          cmp     = 1'b1;
          execAlu = cpuControlPkg::AluCmp;
        end
        cpuControlPkg::FunJr: kind = "jr";
        default:              kind = "bad";
      endcase
    end
    cpuControlPkg::OpAddi, cpuControlPkg::OpAddiu: begin
      kind = "alu";
      trap = 1'b1;
      immB = 1'b1;
    end
    cpuControlPkg::OpSlti: begin
      kind    = "alu";
      cmp     = 1'b1;
      immB    = 1'b1;
      execAlu = cpuControlPkg::AluCmp;
    end
    cpuControlPkg::OpLb: begin
      kind = "load";
      sz   = cpuControlPkg::SizeByte;
    end
    cpuControlPkg::OpLh: begin
      kind = "load";
      sz   = cpuControlPkg::SizeHalf;
    end
    cpuControlPkg::OpLw: kind = "load";
    cpuControlPkg::OpSb: begin
      kind = "store";
      sz   = cpuControlPkg::SizeByte;
    end
    cpuControlPkg::OpSh: begin
      kind = "store";
      sz   = cpuControlPkg::SizeHalf;
    end
    cpuControlPkg::OpSw: kind = "store";
    cpuControlPkg::OpBeq: begin
      kind = "branch";
      cnd  = cpuControlPkg::CondEq;
    end
    cpuControlPkg::OpBne: kind = "branch";
    cpuControlPkg::OpBle: begin
      kind = "branch";
      cnd  = cpuControlPkg::CondLe;
    end
    cpuControlPkg::OpBgt: begin
      kind = "branch";
      cnd  = cpuControlPkg::CondGt;
    end
    cpuControlPkg::OpJ:   kind = "j";
    cpuControlPkg::OpJal: kind = "jal";
    default:              kind = "bad";
  endcase

  {pwc, pw, mr, mw, irw, rw, md, asa, lsc, lt} = '0;
  cond  = '0;
  alu   = '0;
  size  = '0;
  addr  = '0;
  dst   = '0;
  wb    = '0;
  srcB  = '0;
  pcSrc = '0;
  last  = 1'b0;
  j     = idx - 3;

  // Fetch, wait and decode are common to all classes
  if (idx == 0) begin
    mr   = 1'b1;
    irw  = 1'b1;
    pw   = 1'b1;
    srcB = cpuControlPkg::SrcBFour;
    alu  = cpuControlPkg::AluAdd;
  end else if (idx == 2) begin
    srcB = cpuControlPkg::SrcBImmShift;
    alu  = cpuControlPkg::AluAdd;
  end else if (idx > 2) begin
    if (kind == "alu") begin
      if (j == 0) begin
        asa  = 1'b1;
        srcB = immB ? cpuControlPkg::SrcBImm : cpuControlPkg::SrcBReg;
        alu  = execAlu;
      end else if (j == 1) begin
        rw   = 1'b1;
        dst  = cpuControlPkg::DstRd;
        lt   = cmp;
        last = !(trap && ovf);
      end else if (j == 3) begin
        mr    = 1'b1;
        pw    = 1'b1;
        pcSrc = cpuControlPkg::PcMemVector;
        addr  = cpuControlPkg::AddrOvfVector;
        last  = 1'b1;
      end
    end else if (kind == "load" || kind == "store") begin
      if (j == 0) begin
        asa  = 1'b1;
        srcB = cpuControlPkg::SrcBImm;
        alu  = cpuControlPkg::AluAdd;
      end else if (j == 1 && kind == "load") begin
        mr   = 1'b1;
        addr = cpuControlPkg::AddrAluOut;
      end else if (j == 1) begin
        mw   = 1'b1;
        md   = 1'b1;
        lsc  = 1'b1;
        addr = cpuControlPkg::AddrAluOut;
        size = sz;
        last = 1'b1;
      end else if (j == 2) begin
        rw   = 1'b1;
        wb   = cpuControlPkg::WbMemLoad;
        size = sz;
        last = 1'b1;
      end
    end else if (kind == "branch") begin
      pwc   = 1'b1;
      asa   = 1'b1;
      alu   = cpuControlPkg::AluCmp;
      pcSrc = cpuControlPkg::PcAluOut;
      cond  = cnd;
      last  = 1'b1;
    end else if (kind == "jal" && j < 2) begin
      if (j == 0) begin
        srcB = cpuControlPkg::SrcBFour;
        alu  = cpuControlPkg::AluAdd;
      end else begin
        rw  = 1'b1;
        dst = cpuControlPkg::DstRa;
      end
    end else if (kind == "j" || kind == "jal") begin
      pw    = 1'b1;
      pcSrc = cpuControlPkg::PcJumpTarget;
      last  = 1'b1;
    end else if (kind == "jr") begin
      if (j == 0) begin
        asa = 1'b1;
        alu = cpuControlPkg::AluPass;
      end else begin
        pw    = 1'b1;
        pcSrc = cpuControlPkg::PcAluOut;
        last  = 1'b1;
      end
    end else if (j == 1) begin
      // Invalid instruction traps through the bad-op vector
      mr    = 1'b1;
      pw    = 1'b1;
      pcSrc = cpuControlPkg::PcMemVector;
      addr  = cpuControlPkg::AddrBadOpVector;
      last  = 1'b1;
    end
  end
  return {pwc, pw, mr, mw, irw, rw, md, asa, lsc, lt,
          cond, alu, size, addr, dst, wb, srcB, pcSrc};
endfunction

`endif

// File: cpuControl_tb.sv
`timescale 1ns/1ps

module cpuControl_tb;

  localparam int ClkPeriod  = 40;
  localparam int NumEntries = 24;
  localparam int NumRandom  = 160;
  localparam int NumInstr   = 2 * NumEntries + NumRandom;

  logic clk = 1'b0;
  logic reset_in;
  cpuControlPkg::opcodeT opcode;
  cpuControlPkg::functT  funct;
  logic overflow;
  logic pcWriteCond, pcWrite, memRead, memWrite, irWrite;
  logic regWrite, memData, aluSrcA, lsControl, ltOut;
  cpuControlPkg::condT     condControl;
  cpuControlPkg::aluOpT    aluOp;
  cpuControlPkg::lsSizeT   lsSize;
  cpuControlPkg::iorDT     iorD;
  cpuControlPkg::regDstT   regDst;
  cpuControlPkg::memToRegT memToReg;
  cpuControlPkg::aluSrcBT  aluSrcB;
  cpuControlPkg::pcSourceT pcSource;
  logic [29:0] dutWord;

  logic [31:0] lfsr = 32'h93d69802;
  logic running = 1'b0;
  int stepIdx = 0;
  int doneCount = 0;
  int checkCount = 0;
  int errCount = 0;
  string curTest = "reset";
  string curInstr = "none";

  // Opcode in the upper six bits, funct in the lower six
  logic [11:0] codeTab [NumEntries] = '{
    {cpuControlPkg::OpTypeR, cpuControlPkg::FunAdd}, {cpuControlPkg::OpTypeR, cpuControlPkg::FunAnd},
    {cpuControlPkg::OpTypeR, cpuControlPkg::FunSub}, {cpuControlPkg::OpTypeR, cpuControlPkg::FunSlt},
    {cpuControlPkg::OpTypeR, cpuControlPkg::FunJr},  {cpuControlPkg::OpTypeR, 6'h18},
    {cpuControlPkg::OpTypeR, 6'h00},  {cpuControlPkg::OpAddi, 6'h00}, {cpuControlPkg::OpAddiu, 6'h00},
    {cpuControlPkg::OpSlti, 6'h00}, {cpuControlPkg::OpLb, 6'h00}, {cpuControlPkg::OpLh, 6'h00},
    {cpuControlPkg::OpLw, 6'h00},   {cpuControlPkg::OpSb, 6'h00}, {cpuControlPkg::OpSh, 6'h00},
    {cpuControlPkg::OpSw, 6'h00},   {cpuControlPkg::OpBeq, 6'h00}, {cpuControlPkg::OpBne, 6'h00},
    {cpuControlPkg::OpBle, 6'h00},  {cpuControlPkg::OpBgt, 6'h00}, {cpuControlPkg::OpJ, 6'h00},
    {cpuControlPkg::OpJal, 6'h00},  {6'h0F, 6'h00}, {6'h3F, 6'h00}
  };
  string nameTab [NumEntries] = '{
    "add", "and", "sub", "slt", "jr", "badFunct18", "badFunct00", "addi", "addiu",
    "slti", "lb", "lh", "lw", "sb", "sh", "sw", "beq", "bne", "ble", "bgt", "j",
    "jal", "badOp0F", "badOp3F"
  };

  cpuControl dut (.*);

  assign dutWord = {pcWriteCond, pcWrite, memRead, memWrite, irWrite, regWrite, memData,
                    aluSrcA, lsControl, ltOut, condControl, aluOp, lsSize, iorD, regDst,
                    memToReg, aluSrcB, pcSource};

  `include "cpuControlRef.svh"

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task automatic takeBits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic reportTest(input string name, input int chkStart, input int errStart);
    $display("%s: %0d checks, %0d errors", name, checkCount - chkStart, errCount - errStart);
  endtask

  // One instruction, called on the edge that enters fetch
  task automatic runInstr(input int entry, input logic ovf, input string test);
    int target;
    logic [31:0] bits;
    opcode <= codeTab[entry][11:6];
    if (codeTab[entry][11:6] == cpuControlPkg::OpTypeR) begin
      funct <= codeTab[entry][5:0];
    end else begin
      takeBits(6, bits);
      funct <= bits[5:0];
    end
    overflow <= ovf;
    curTest  = test;
    curInstr = $sformatf("%s ovf=%0d", nameTab[entry], ovf);
    target   = doneCount + 1;
    while (doneCount != target) begin
      @(posedge clk);
    end
  endtask

  always @(negedge clk) begin : compareStep
    logic [29:0] expWord;
    logic lastStep;
    if (running) begin
      expWord = expectedControl(opcode, funct, overflow, stepIdx, lastStep);
      checkValue($sformatf("%s %s step %0d", curTest, curInstr, stepIdx),
                 {2'b00, expWord}, {2'b00, dutWord});
      if (lastStep) begin
        stepIdx = 0;
        doneCount++;
      end else begin
        stepIdx++;
      end
    end else begin
      checkValue("reset", 32'h0, {2'b00, dutWord});
    end
  end

  initial begin
    int chkStart;
    int errStart;
    int entry;
    logic [31:0] bits;
    reset_in = 1'b1;
    opcode   = '0;
    funct    = '0;
    overflow = 1'b0;
    repeat (8) @(posedge clk);
    reset_in <= 1'b0;
    @(posedge clk);
    reportTest("reset", 0, 0);
    running <= 1'b1;

    chkStart = checkCount;
    errStart = errCount;
    for (int i = 0; i < NumEntries; i++) begin
      runInstr(i, 1'b0, "directed");
      runInstr(i, 1'b1, "directed");
    end
    reportTest("directed", chkStart, errStart);

    chkStart = checkCount;
    errStart = errCount;
    for (int i = 0; i < NumRandom; i++) begin
      takeBits(5, bits);
      entry = bits % NumEntries;
      takeBits(1, bits);
      runInstr(entry, bits[0], "random");
    end
    reportTest("random", chkStart, errStart);

    $display("Total: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Longest instruction path is 7 cycles
  initial begin
    #(NumInstr * 7 * ClkPeriod + 40 * ClkPeriod);
    $display("Timeout: the instruction sequence did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: cpuControl.f
+incdir+.
cpuControlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlEncoder.sv
cpuControl.sv
cpuControl_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module cpuControl_tb -Mdir obj_dir -o simv -f cpuControl.f ||
  { echo "Build failed"; exit 1; }
simOut=$(./obj_dir/simv)
echo "$simOut"
echo "$simOut" | grep -q "TESTS PASSED" &&
  echo "Simulation run succeeded" ||
  { echo "Simulation run failed"; exit 1; }
